/* verilog/aes_pkg.sv */
package aes_pkg;

  // Datapath widths
  localparam int BLOCK_BITS = 128;
  localparam int WORD_BITS  = 32;
  localparam int BYTE_BITS  = 8;
  localparam int NUM_BYTES  = 16;
  localparam int NUM_COLS   = 4;

  // Rounds after the initial whitening, keys including the whitening key
  localparam int NUM_ROUNDS   = 10;
  localparam int NUM_KEYS     = 11;
  localparam int PIPE_LATENCY = 4;

  typedef logic [BLOCK_BITS-1:0] aes_block_t;
  typedef logic [BYTE_BITS-1:0]  aes_byte_t;
  typedef logic [WORD_BITS-1:0]  aes_word_t;

  // Column-major state, byte 0 and column 0 sit in the top bits
  typedef union packed {
    aes_byte_t [0:NUM_BYTES-1] bytes;
    aes_word_t [0:NUM_COLS-1]  cols;
  } aes_state_u;

  typedef aes_block_t aes_round_keys_t [NUM_KEYS];

  // Forward S-box
  localparam aes_byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Round constants, already placed in the top byte of the word
  localparam aes_word_t RCON [1:NUM_ROUNDS] = '{
    32'h01000000, 32'h02000000, 32'h04000000, 32'h08000000, 32'h10000000,
    32'h20000000, 32'h40000000, 32'h80000000, 32'h1b000000, 32'h36000000
  };

endpackage

/* verilog/aes_sub_bytes.sv */
module aes_sub_bytes (
  input  aes_pkg::aes_block_t state_in,
  output aes_pkg::aes_block_t state_out
);

  wire aes_pkg::aes_state_u in_u;
  wire aes_pkg::aes_state_u out_u;

  assign in_u = state_in;

  // One table lookup per byte, position unchanged
  for (genvar i = 0; i < aes_pkg::NUM_BYTES; i++) begin : g_byte
    assign out_u.bytes[i] = aes_pkg::SBOX[in_u.bytes[i]];
  end

  assign state_out = out_u;

endmodule

/* verilog/aes_mix_columns.sv */
module aes_mix_columns (
  input  aes_pkg::aes_block_t state_in,
  output aes_pkg::aes_block_t state_out
);

  // Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
  localparam aes_pkg::aes_byte_t GF_POLY = 8'h1b;

  function automatic aes_pkg::aes_byte_t gf_mul2(input aes_pkg::aes_byte_t b);
    return {b[aes_pkg::BYTE_BITS-2:0], 1'b0} ^ (GF_POLY & {aes_pkg::BYTE_BITS{b[7]}});
  endfunction

  function automatic aes_pkg::aes_byte_t gf_mul3(input aes_pkg::aes_byte_t b);
    return gf_mul2(b) ^ b;
  endfunction

  wire aes_pkg::aes_state_u in_u;
  wire aes_pkg::aes_state_u out_u;

  assign in_u = state_in;

  for (genvar c = 0; c < aes_pkg::NUM_COLS; c++) begin : g_col
    wire aes_pkg::aes_byte_t b0;
    wire aes_pkg::aes_byte_t b1;
    wire aes_pkg::aes_byte_t b2;
    wire aes_pkg::aes_byte_t b3;

    // Row 0 is the top byte of the column word
    assign {b0, b1, b2, b3} = in_u.cols[c];

    // Circulant matrix rows 2 3 1 1
    assign out_u.cols[c] = {
      gf_mul2(b0) ^ gf_mul3(b1) ^ b2 ^ b3,
      b0 ^ gf_mul2(b1) ^ gf_mul3(b2) ^ b3,
      b0 ^ b1 ^ gf_mul2(b2) ^ gf_mul3(b3),
      gf_mul3(b0) ^ b1 ^ b2 ^ gf_mul2(b3)
    };
  end

  assign state_out = out_u;

endmodule

/* verilog/aes_round.sv */
module aes_round #(
  parameter int FINAL = 0
) (
  input  aes_pkg::aes_block_t state_in,
  input  aes_pkg::aes_block_t round_key,
  output aes_pkg::aes_block_t state_out
);

  localparam int ROWS = aes_pkg::NUM_BYTES / aes_pkg::NUM_COLS;

  wire aes_pkg::aes_block_t subbed;
  wire aes_pkg::aes_state_u sub_u;
  wire aes_pkg::aes_state_u shift_u;
  wire aes_pkg::aes_block_t mixed;

  aes_sub_bytes sub_bytes_i (
    .state_in  (state_in),
    .state_out (subbed)
  );

  assign sub_u = subbed;

  // ShiftRows, byte index is col*4 + row
  // Row r rotates left by r, so new column c takes old column c+r
  for (genvar c = 0; c < aes_pkg::NUM_COLS; c++) begin : g_shift_col
    for (genvar r = 0; r < ROWS; r++) begin : g_shift_row
      assign shift_u.bytes[c*ROWS + r] =
        sub_u.bytes[((c + r) % aes_pkg::NUM_COLS)*ROWS + r];
    end
  end

  // Last round skips MixColumns
  if (FINAL != 0) begin : g_final
    assign mixed = shift_u;
  end else begin : g_mix
    aes_mix_columns mix_columns_i (
      .state_in  (shift_u),
      .state_out (mixed)
    );
  end

  // AddRoundKey
  assign state_out = mixed ^ round_key;

endmodule

/* verilog/aes_key_schedule.sv */
module aes_key_schedule (
  input  aes_pkg::aes_block_t      key,
  output aes_pkg::aes_round_keys_t round_keys
);

  localparam int WB = aes_pkg::WORD_BITS;
  localparam int BB = aes_pkg::BYTE_BITS;
  localparam int LAST_COL = aes_pkg::NUM_COLS - 1;

  // Whitening key is the cipher key
  assign round_keys[0] = key;

  for (genvar r = 1; r < aes_pkg::NUM_KEYS; r++) begin : g_key
    wire aes_pkg::aes_state_u prev_u;
    wire aes_pkg::aes_state_u next_u;
    wire aes_pkg::aes_word_t  rot_word;
    wire aes_pkg::aes_word_t  sub_word;
    wire aes_pkg::aes_word_t  g_word;

    assign prev_u = round_keys[r-1];

    // RotWord on the last column
    assign rot_word = {prev_u.cols[LAST_COL][WB-BB-1:0], prev_u.cols[LAST_COL][WB-1 -: BB]};

    // SubWord
    for (genvar b = 0; b < WB / BB; b++) begin : g_sub
      assign sub_word[WB-1-b*BB -: BB] = aes_pkg::SBOX[rot_word[WB-1-b*BB -: BB]];
    end

    assign g_word = sub_word ^ aes_pkg::RCON[r];

    // Word chain, each new column folds in the one before it
    assign next_u.cols[0] = prev_u.cols[0] ^ g_word;
    for (genvar c = 1; c < aes_pkg::NUM_COLS; c++) begin : g_chain
      assign next_u.cols[c] = prev_u.cols[c] ^ next_u.cols[c-1];
    end

    assign round_keys[r] = next_u;
  end

endmodule

/* verilog/aes_pipe_segment.sv */
module aes_pipe_segment #(
  parameter int FIRST_ROUND = 1,
  parameter int LAST_ROUND  = 3
) (
  input  logic                     clk,
  input  logic                     reset,
  input  aes_pkg::aes_block_t      state_in,
  input  logic                     valid_in,
  input  aes_pkg::aes_round_keys_t keys_in,
  output aes_pkg::aes_block_t      state_out,
  output logic                     valid_out,
  output aes_pkg::aes_round_keys_t keys_out
);

  wire aes_pkg::aes_block_t chain_out;

  if (FIRST_ROUND == 0) begin : g_whiten
    // Initial AddRoundKey only
    assign chain_out = state_in ^ keys_in[0];
  end else begin : g_rounds
    wire aes_pkg::aes_block_t stage [FIRST_ROUND:LAST_ROUND+1];

    assign stage[FIRST_ROUND] = state_in;

    for (genvar r = FIRST_ROUND; r <= LAST_ROUND; r++) begin : g_round
      aes_round #(
        .FINAL ((r == aes_pkg::NUM_ROUNDS) ? 1 : 0)
      ) round_i (
        .state_in  (stage[r]),
        .round_key (keys_in[r]),
        .state_out (stage[r+1])
      );
    end

    assign chain_out = stage[LAST_ROUND+1];
  end

  // Stage register, keys travel with their block
  always_ff @(posedge clk) begin
    if (reset) begin
      state_out <= '0;
      valid_out <= 1'b0;
      for (int k = 0; k < aes_pkg::NUM_KEYS; k++) begin
        keys_out[k] <= '0;
      end
    end else begin
      state_out <= chain_out;
      valid_out <= valid_in;
      // Keys already consumed are dropped here
      for (int k = 0; k < aes_pkg::NUM_KEYS; k++) begin
        keys_out[k] <= (k > LAST_ROUND) ? keys_in[k] : '0;
      end
    end
  end

endmodule

/* verilog/aes_encrypt_pipe.sv */
module aes_encrypt_pipe (
  input  logic                clk,
  input  logic                reset,
  input  aes_pkg::aes_block_t plaintext,
  input  aes_pkg::aes_block_t key,
  input  logic                valid_in,
  output aes_pkg::aes_block_t ciphertext,
  output logic                valid_out
);

  aes_pkg::aes_round_keys_t round_keys;

  aes_pkg::aes_block_t      s1_state;
  logic                     s1_valid;
  aes_pkg::aes_round_keys_t s1_keys;
  aes_pkg::aes_block_t      s2_state;
  logic                     s2_valid;
  aes_pkg::aes_round_keys_t s2_keys;
  aes_pkg::aes_block_t      s3_state;
  logic                     s3_valid;
  aes_pkg::aes_round_keys_t s3_keys;

  aes_key_schedule key_schedule_i (
    .key        (key),
    .round_keys (round_keys)
  );

  // Whitening
  aes_pipe_segment #(.FIRST_ROUND(0), .LAST_ROUND(0)) seg0_i (
    .clk (clk), .reset (reset),
    .state_in  (plaintext), .valid_in  (valid_in), .keys_in  (round_keys),
    .state_out (s1_state),  .valid_out (s1_valid), .keys_out (s1_keys)
  );

  aes_pipe_segment #(.FIRST_ROUND(1), .LAST_ROUND(3)) seg1_i (
    .clk (clk), .reset (reset),
    .state_in  (s1_state), .valid_in  (s1_valid), .keys_in  (s1_keys),
    .state_out (s2_state), .valid_out (s2_valid), .keys_out (s2_keys)
  );

  aes_pipe_segment #(.FIRST_ROUND(4), .LAST_ROUND(6)) seg2_i (
    .clk (clk), .reset (reset),
    .state_in  (s2_state), .valid_in  (s2_valid), .keys_in  (s2_keys),
    .state_out (s3_state), .valid_out (s3_valid), .keys_out (s3_keys)
  );

  // Rounds 7 to 10, nothing left to forward
  aes_pipe_segment #(.FIRST_ROUND(7), .LAST_ROUND(10)) seg3_i (
    .clk (clk), .reset (reset),
    .state_in  (s3_state),   .valid_in  (s3_valid),  .keys_in  (s3_keys),
    .state_out (ciphertext), .valid_out (valid_out), .keys_out ()
  );

endmodule

/* testbench/aes_model.svh */
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Forward S-box, filled at time zero from field arithmetic
logic [7:0] ref_sbox [256];

// Multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] acc;
  logic [7:0] x;
  acc = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      acc = acc ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return acc;
endfunction

// Inverse by exhaustive search, zero maps to zero
function automatic logic [7:0] gf_inv(input logic [7:0] a);
  logic [7:0] inv;
  inv = 8'h00;
  for (int b = 1; b < 256; b++) begin
    if (gf_mul(a, b[7:0]) == 8'h01) begin
      inv = b[7:0];
    end
  end
  return inv;
endfunction

// Inverse followed by the affine map
function automatic void build_sbox();
  logic [7:0] v;
  for (int i = 0; i < 256; i++) begin
    v = gf_inv(i[7:0]);
    ref_sbox[i] = v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^
                  {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]} ^ 8'h63;
  end
endfunction

// SubBytes and ShiftRows, byte n of the block is column n/4, row n%4
function automatic logic [127:0] sub_shift_rows(input logic [127:0] s);
  logic [127:0] o;
  for (int c = 0; c < 4; c++) begin
    for (int r = 0; r < 4; r++) begin
      o[127-8*(c*4+r) -: 8] = ref_sbox[s[127-8*(((c+r)%4)*4+r) -: 8]];
    end
  end
  return o;
endfunction

function automatic logic [127:0] mix_state(input logic [127:0] s);
  logic [127:0] o;
  logic [7:0]   a0;
  logic [7:0]   a1;
  logic [7:0]   a2;
  logic [7:0]   a3;
  for (int c = 0; c < 4; c++) begin
    {a0, a1, a2, a3} = s[127-32*c -: 32];
    o[127-32*c -: 32] = {
      gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3,
      a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3,
      a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03),
      gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02)
    };
  end
  return o;
endfunction

// One step of the AES-128 key expansion
function automatic logic [127:0] next_round_key(input logic [127:0] k, input logic [7:0] rcon);
  logic [31:0] w0;
  logic [31:0] w1;
  logic [31:0] w2;
  logic [31:0] w3;
  logic [31:0] t;
  {w0, w1, w2, w3} = k;
  t = {w3[23:0], w3[31:24]};
  t = {ref_sbox[t[31:24]], ref_sbox[t[23:16]], ref_sbox[t[15:8]], ref_sbox[t[7:0]]};
  w0 = w0 ^ t ^ {rcon, 24'h000000};
  w1 = w1 ^ w0;
  w2 = w2 ^ w1;
  w3 = w3 ^ w2;
  return {w0, w1, w2, w3};
endfunction

function automatic logic [127:0] encrypt_block(input logic [127:0] pt, input logic [127:0] k);
  logic [127:0] s;
  logic [127:0] rk;
  logic [7:0]   rcon;
  rk = k;
  s = pt ^ rk;
  rcon = 8'h01;
  for (int r = 1; r <= 10; r++) begin
    rk = next_round_key(rk, rcon);
    rcon = gf_mul(rcon, 8'h02);
    s = sub_shift_rows(s);
    if (r != 10) begin
      s = mix_state(s);
    end
    s = s ^ rk;
  end
  return s;
endfunction

`endif

/* testbench/tb_aes_encrypt_pipe.sv */
module tb_aes_encrypt_pipe;

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DELAY   = 10;
  localparam int RESET_CYCLES  = 16;
  localparam int KAT_CYCLES    = 8;
  localparam int STREAM_CYCLES = 600;
  localparam int GAP_CYCLES    = 300;
  localparam int FLUSH_CYCLES  = 12;
  localparam int KEY_CYCLES    = 2;
  localparam int DRAIN_CYCLES  = 8;
  localparam int MAX_CYCLES    = RESET_CYCLES + KAT_CYCLES + STREAM_CYCLES + GAP_CYCLES +
                                 FLUSH_CYCLES + KEY_CYCLES + DRAIN_CYCLES + 50;
  localparam int LAT = aes_pkg::PIPE_LATENCY;

  // FIPS-197 appendix C.1 and the all-zero vector
  localparam aes_pkg::aes_block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_pkg::aes_block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_pkg::aes_block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_pkg::aes_block_t ZERO_CT  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic                clk = 1'b0;
  logic                reset;
  aes_pkg::aes_block_t plaintext;
  aes_pkg::aes_block_t key;
  logic                valid_in;
  aes_pkg::aes_block_t ciphertext;
  logic                valid_out;

  integer              seed;
  int                  value_errors;
  int                  protocol_errors;
  int                  cycle_count;
  string               test_name;
  aes_pkg::aes_block_t expected_q [$];
  string               name_q [$];
  logic [LAT-1:0]      valid_pipe;
  logic                reset_seen;

  `include "aes_model.svh"

  aes_encrypt_pipe aes_encrypt_pipe_i (
    .clk        (clk),
    .reset      (reset),
    .plaintext  (plaintext),
    .key        (key),
    .valid_in   (valid_in),
    .ciphertext (ciphertext),
    .valid_out  (valid_out)
  );

  initial begin
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic check_block(input string name, input aes_pkg::aes_block_t expected,
                             input aes_pkg::aes_block_t actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s valid_out: expected %b, actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  function automatic aes_pkg::aes_block_t rand_block();
    aes_pkg::aes_block_t b;
    for (int i = 0; i < 4; i++) begin
      b[127-32*i -: 32] = $random(seed);
    end
    return b;
  endfunction

  task automatic drive_block(input aes_pkg::aes_block_t pt, input aes_pkg::aes_block_t k,
                             input logic v);
    @(posedge clk);
    #DRIVE_DELAY;
    plaintext = pt;
    key       = k;
    valid_in  = v;
  endtask

  // Random data keeps flowing without valid
  task automatic drive_idle(input int n);
    repeat (n) drive_block(rand_block(), rand_block(), 1'b0);
  endtask

  // Outputs settle by the falling edge and the next inputs are already driven
  always @(negedge clk) begin
    check_valid(test_name, valid_pipe[LAT-1], valid_out);
    if (reset_seen) begin
      check_block("reset_clear", '0, ciphertext);
    end
    if (valid_out === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("valid_out went high in %s with no block in flight", test_name);
        protocol_errors++;
      end else begin
        check_block(name_q.pop_front(), expected_q.pop_front(), ciphertext);
      end
    end
    // Model of what the next rising edge does
    if (reset) begin
      valid_pipe = '0;
      expected_q.delete();
      name_q.delete();
    end else begin
      valid_pipe = {valid_pipe[LAT-2:0], valid_in};
      if (valid_in) begin
        expected_q.push_back(encrypt_block(plaintext, key));
        name_q.push_back(test_name);
      end
    end
    reset_seen = reset;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    aes_pkg::aes_block_t same_pt;
    logic [31:0]         gap_word;
    seed            = 32'h3704;
    value_errors    = 0;
    protocol_errors = 0;
    cycle_count     = 0;
    test_name       = "reset";
    reset           = 1'b1;
    plaintext       = '0;
    key             = '0;
    valid_in        = 1'b0;
    valid_pipe      = '0;
    reset_seen      = 1'b1;
    build_sbox();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    test_name = "known_answer";
    check_block("fips_model", FIPS_CT, encrypt_block(FIPS_PT, FIPS_KEY));
    check_block("zero_model", ZERO_CT, encrypt_block('0, '0));
    drive_block(FIPS_PT, FIPS_KEY, 1'b1);
    drive_block('0, '0, 1'b1);
    drive_idle(KAT_CYCLES - 2);

    test_name = "back_to_back";
    repeat (STREAM_CYCLES) drive_block(rand_block(), rand_block(), 1'b1);

    test_name = "gapped";
    repeat (GAP_CYCLES) begin
      gap_word = $random(seed);
      drive_block(rand_block(), rand_block(), gap_word[0]);
    end

    // Three blocks in flight plus one presented with reset must all vanish
    test_name = "reset_in_flight";
    repeat (3) drive_block(rand_block(), rand_block(), 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    reset    = 1'b1;
    valid_in = 1'b1;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset    = 1'b0;
    valid_in = 1'b0;
    drive_idle(FLUSH_CYCLES - 6);

    test_name = "key_per_block";
    same_pt = rand_block();
    drive_block(same_pt, rand_block(), 1'b1);
    drive_block(same_pt, rand_block(), 1'b1);

    test_name = "drain";
    drive_idle(DRAIN_CYCLES);
    if (expected_q.size() != 0) begin
      $display("%0d expected blocks never came out of the pipeline", expected_q.size());
      protocol_errors++;
    end

    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+testbench
verilog/aes_pkg.sv
verilog/aes_sub_bytes.sv
verilog/aes_mix_columns.sv
verilog/aes_round.sv
verilog/aes_key_schedule.sv
verilog/aes_pipe_segment.sv
verilog/aes_encrypt_pipe.sv
testbench/tb_aes_encrypt_pipe.sv

/* Bender.yml */
package:
  name: aes_encrypt_pipe

sources:
  - files:
      - verilog/aes_pkg.sv
      - verilog/aes_sub_bytes.sv
      - verilog/aes_mix_columns.sv
      - verilog/aes_round.sv
      - verilog/aes_key_schedule.sv
      - verilog/aes_pipe_segment.sv
      - verilog/aes_encrypt_pipe.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_aes_encrypt_pipe.sv
